//--- adc_capture_pkg.sv
package adc_capture_pkg;

	// adc channel layout
	localparam int LANES = 8;
	localparam int LANE_W = 16;
	localparam int CONV_W = 12; // converter bits, low end of each lane
	localparam int WORD_W = LANES * LANE_W;

	// packer ratio, samples in to ram words out
	localparam int PACK_IN = 4;
	localparam int PACK_OUT = 3;

	typedef logic [LANE_W-1:0] lane_t;

	// lane 0 in the low 16 bits
	typedef lane_t [LANES-1:0] sample_word_t;

	// zero keeps every sample
	typedef logic [3:0] decim_t;

	typedef enum logic
	{
		AVG_PICK = 1'b0, // last sample of the group
		AVG_SUM = 1'b1 // lane-wise wrapping sum
	} avg_mode_t;

endpackage

//--- adc_capture_top.sv
module adc_capture_top #(
	parameter int ADDR_W = 15
) (
	input logic adc_clkinp,
	input logic rst_n,
	input adc_capture_pkg::sample_word_t adc_sample,
	input logic trig_in,
	input logic state_reset,
	input logic [ADDR_W:0] rec_length,
	input adc_capture_pkg::decim_t decim_div,
	input adc_capture_pkg::avg_mode_t avg_mode,
	input logic pack_en,
	output logic trig_ack,
	output logic rcv_done,
	output logic ram_en,
	output logic ram_wren,
	output logic [ADDR_W-1:0] ram_addr,
	output adc_capture_pkg::sample_word_t ram_data
);
	import adc_capture_pkg::*;

	logic dec_valid;
	sample_word_t dec_data;
	logic pk_valid;
	sample_word_t pk_data;

	capture_cfg_if #(.ADDR_W(ADDR_W)) cfg_bus ();

	// options latched at the trigger
	capture_config #(.ADDR_W(ADDR_W)) u_capture_config (
		.adc_clkinp (adc_clkinp),
		.rst_n (rst_n),
		.rec_length (rec_length),
		.decim_div (decim_div),
		.avg_mode (avg_mode),
		.pack_en (pack_en),
		.cfg (cfg_bus.cfg)
	);

	sample_decimator u_sample_decimator (
		.adc_clkinp (adc_clkinp),
		.rst_n (rst_n),
		.adc_sample (adc_sample),
		.cfg (cfg_bus.stage),
		.dec_valid (dec_valid),
		.dec_data (dec_data)
	);

	sample_packer u_sample_packer (
		.adc_clkinp (adc_clkinp),
		.rst_n (rst_n),
		.dec_valid (dec_valid),
		.dec_data (dec_data),
		.cfg (cfg_bus.stage),
		.pk_valid (pk_valid),
		.pk_data (pk_data)
	);

	// trigger handshake and ram write port
	capture_sequencer #(.ADDR_W(ADDR_W)) u_capture_sequencer (
		.adc_clkinp (adc_clkinp),
		.rst_n (rst_n),
		.trig_in (trig_in),
		.state_reset (state_reset),
		.pk_valid (pk_valid),
		.pk_data (pk_data),
		.cfg (cfg_bus.seq),
		.trig_ack (trig_ack),
		.rcv_done (rcv_done),
		.ram_en (ram_en),
		.ram_wren (ram_wren),
		.ram_addr (ram_addr),
		.ram_data (ram_data)
	);

endmodule

//--- capture_cfg_if.sv
interface capture_cfg_if #(
	parameter int ADDR_W = 15
);
	import adc_capture_pkg::*;

	// options held for the length of one record
	logic [ADDR_W:0] rec_length;
	decim_t decim_div;
	avg_mode_t avg_mode;
	logic pack_en;

	// run control from the sequencer
	logic start; // single cycle, capture begins
	logic run; // high while the record is being taken

	modport cfg (
		output rec_length, decim_div, avg_mode, pack_en,
		input start
	);

	modport seq (
		output start, run,
		input rec_length
	);

	modport stage (
		input run, decim_div, avg_mode, pack_en
	);

endinterface

//--- capture_config.sv
module capture_config #(
	parameter int ADDR_W = 15
) (
	input logic adc_clkinp,
	input logic rst_n,
	input logic [ADDR_W:0] rec_length,
	input adc_capture_pkg::decim_t decim_div,
	input adc_capture_pkg::avg_mode_t avg_mode,
	input logic pack_en,
	capture_cfg_if.cfg cfg
);
	import adc_capture_pkg::*;

	// option snapshot taken on the start pulse only,
	// so host writes during a record have no effect on it
	always_ff @(posedge adc_clkinp)
	begin
		if (!rst_n)
		begin
			cfg.rec_length <= '0;
			cfg.decim_div <= '0;
			cfg.avg_mode <= AVG_PICK;
			cfg.pack_en <= 1'b0;
		end
		else if (cfg.start)
		begin
			cfg.rec_length <= rec_length;
			cfg.decim_div <= decim_div;
			cfg.avg_mode <= avg_mode;
			cfg.pack_en <= pack_en;
		end
	end

endmodule

//--- capture_sequencer.sv
module capture_sequencer #(
	parameter int ADDR_W = 15
) (
	input logic adc_clkinp,
	input logic rst_n,
	input logic trig_in,
	input logic state_reset,
	input logic pk_valid,
	input adc_capture_pkg::sample_word_t pk_data,
	capture_cfg_if.seq cfg,
	output logic trig_ack,
	output logic rcv_done,
	output logic ram_en,
	output logic ram_wren,
	output logic [ADDR_W-1:0] ram_addr,
	output adc_capture_pkg::sample_word_t ram_data
);

	typedef enum logic [1:0]
	{
		S_IDLE,
		S_RUN,
		S_DONE
	} seq_state_t;

	seq_state_t state;
	logic [ADDR_W:0] wr_cnt; // words written so far
	logic rec_full;
	logic wr_go;

	assign rec_full = (wr_cnt == cfg.rec_length);

	// no write once the record is full, a late packer word is dropped
	assign wr_go = (state == S_RUN) && pk_valid && !rec_full && !state_reset;

	// start is seen by the config block at the trigger edge itself
	assign cfg.start = (state == S_IDLE) && trig_in && !state_reset;
	assign cfg.run = (state == S_RUN);

	assign trig_ack = (state == S_RUN);
	assign ram_en = (state == S_RUN);
	assign rcv_done = (state == S_DONE); // held until state_reset

	always_ff @(posedge adc_clkinp)
	begin
		if (!rst_n || state_reset)
		begin
			state <= S_IDLE;
			wr_cnt <= '0;
			ram_wren <= 1'b0;
			ram_addr <= '0;
		end
		else
		begin
			ram_wren <= wr_go;
			case (state)
				S_IDLE:
				begin
					if (trig_in)
					begin
						state <= S_RUN;
						wr_cnt <= '0;
					end
				end
				S_RUN:
				begin
					if (rec_full)
						state <= S_DONE; // zero length ends here too
					else if (pk_valid)
					begin
						ram_addr <= wr_cnt[ADDR_W-1:0];
						wr_cnt <= wr_cnt + 1'b1;
					end
				end
				S_DONE:
				begin
					state <= S_DONE; // trigger ignored
				end
				default:
				begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (wr_go)
			ram_data <= pk_data;
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_adc_capture -o sim_adc_capture

# the log decides the result, so a fatal exit must not skip the search
./obj_dir/sim_adc_capture > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
	exit 1
fi

if ! grep -q "all tests passed" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi

//--- sample_decimator.sv
module sample_decimator (
	input logic adc_clkinp,
	input logic rst_n,
	input adc_capture_pkg::sample_word_t adc_sample,
	capture_cfg_if.stage cfg,
	output logic dec_valid,
	output adc_capture_pkg::sample_word_t dec_data
);
	import adc_capture_pkg::*;

	decim_t phase; // position inside the group
	sample_word_t acc;
	sample_word_t acc_next;
	logic group_end;

	assign group_end = (phase == cfg.decim_div);

	// first sample of a group loads, the rest add per lane
	always_comb
	begin
		for (int i = 0; i < LANES; i++)
		begin
			if ((cfg.avg_mode == AVG_SUM) && (phase != '0))
				acc_next[i] = acc[i] + adc_sample[i]; // 16 bit wrap
			else
				acc_next[i] = adc_sample[i];
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (!rst_n)
		begin
			phase <= '0;
			dec_valid <= 1'b0;
		end
		else if (!cfg.run)
		begin
			phase <= '0; // next record starts a fresh group
			dec_valid <= 1'b0;
		end
		else
		begin
			dec_valid <= group_end;
			if (group_end)
				phase <= '0;
			else
				phase <= phase + 4'd1;
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (cfg.run)
		begin
			acc <= acc_next;
			if (group_end)
				dec_data <= acc_next; // includes the current sample
		end
	end

endmodule

//--- sample_packer.sv
module sample_packer (
	input logic adc_clkinp,
	input logic rst_n,
	input logic dec_valid,
	input adc_capture_pkg::sample_word_t dec_data,
	capture_cfg_if.stage cfg,
	output logic pk_valid,
	output adc_capture_pkg::sample_word_t pk_data
);
	import adc_capture_pkg::*;

	localparam int PH_W = $clog2(PACK_IN);
	localparam int CHUNK_W = WORD_W * PACK_OUT / PACK_IN; // 96 bits of conversions
	localparam int SPILL_W = WORD_W - CHUNK_W; // room left in a word after one chunk

	logic [PH_W-1:0] phase;
	logic [CHUNK_W-1:0] chunk;
	logic [CHUNK_W-1:0] carry; // stream bits not yet written

	// strip the unused top bits of each lane, lane 0 lowest
	always_comb
	begin
		for (int i = 0; i < LANES; i++)
			chunk[i*CONV_W +: CONV_W] = dec_data[i][CONV_W-1:0];
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (!rst_n || !cfg.run)
		begin
			phase <= '0;
			pk_valid <= 1'b0;
		end
		else if (!cfg.pack_en)
		begin
			phase <= '0;
			pk_valid <= dec_valid; // passthrough
		end
		else
		begin
			pk_valid <= dec_valid && (phase != '0);
			if (dec_valid)
				phase <= phase + 1'b1; // wraps after the fourth sample
		end
	end

	// four chunks make one 384 bit stream, cut into three words
	always_ff @(posedge adc_clkinp)
	begin
		if (dec_valid)
		begin
			if (!cfg.pack_en)
				pk_data <= dec_data;
			else
			begin
				case (phase)
					2'd0:
					begin
						carry <= chunk;
					end
					2'd1:
					begin
						pk_data <= {chunk[SPILL_W-1:0], carry};
						carry[2*SPILL_W-1:0] <= chunk[CHUNK_W-1:SPILL_W];
					end
					2'd2:
					begin
						pk_data <= {chunk[2*SPILL_W-1:0], carry[2*SPILL_W-1:0]};
						carry[SPILL_W-1:0] <= chunk[CHUNK_W-1:2*SPILL_W];
					end
					default:
					begin
						pk_data <= {chunk, carry[SPILL_W-1:0]}; // group closes
					end
				endcase
			end
		end
	end

endmodule

//--- tb_adc_capture.sv
module tb_adc_capture;
	import adc_capture_pkg::*;

	localparam int ADDR_W = 15;
	localparam int MAX_N = 64;
	localparam int CHUNK_W = LANES * CONV_W;
	localparam int N_PLAIN = 30;
	localparam int N_PICK = 48;
	localparam int N_SUM = 36;
	localparam int N_PACK0 = 16;
	localparam int N_PACK1 = 32;
	localparam int N_ABORT = 30;
	localparam int N_DONE = 10;
	localparam int N_IGNORED = 6; // driven while done
	localparam int N_REARM = 20;
	localparam int TOTAL_SAMPLES = N_PLAIN + N_PICK + N_SUM + N_PACK0 + N_PACK1 + N_ABORT
		+ N_DONE + N_IGNORED + N_REARM;
	localparam int CYCLE_LIMIT = 20 * TOTAL_SAMPLES + 200;

	logic adc_clkinp;
	logic rst_n;
	sample_word_t adc_sample;
	logic trig_in;
	logic state_reset;
	logic [ADDR_W:0] rec_length;
	decim_t decim_div;
	avg_mode_t avg_mode;
	logic pack_en;
	logic trig_ack;
	logic rcv_done;
	logic ram_en;
	logic ram_wren;
	logic [ADDR_W-1:0] ram_addr;
	sample_word_t ram_data;

	sample_word_t samples [MAX_N];
	sample_word_t exp_q[$]; // expected ram words in write order
	int wr_idx;
	logic expect_writes;
	int cycles;

	adc_capture_top #(.ADDR_W(ADDR_W)) u_adc_capture_top (
		.adc_clkinp (adc_clkinp),
		.rst_n (rst_n),
		.adc_sample (adc_sample),
		.trig_in (trig_in),
		.state_reset (state_reset),
		.rec_length (rec_length),
		.decim_div (decim_div),
		.avg_mode (avg_mode),
		.pack_en (pack_en),
		.trig_ack (trig_ack),
		.rcv_done (rcv_done),
		.ram_en (ram_en),
		.ram_wren (ram_wren),
		.ram_addr (ram_addr),
		.ram_data (ram_data)
	);

	always #10 adc_clkinp = ~adc_clkinp;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		abort_run($sformatf("[FAIL] %0t %s", $time, msg));
	endtask

	task automatic check_word(input sample_word_t got, input sample_word_t exp, input int idx);
		if (got !== exp)
			report_mismatch($sformatf("write %0d data %h, expected %h", idx, got, exp));
	endtask

	task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
		if (got !== exp)
			report_mismatch($sformatf("ram_addr %0d, expected %0d", got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		if (got !== exp)
			report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
	endtask

	// decimate, pack by the stream rule, cut to the record length
	function automatic void build_expected(input int n, input decim_t div, input avg_mode_t mode,
		input logic pk, input int len);
		sample_word_t dec_q[$];
		sample_word_t acc;
		logic [WORD_W-1:0] bits;
		int grp;
		int s;
		int n_words;
		exp_q.delete();
		grp = int'(div) + 1;
		for (int g = 0; (g + 1) * grp <= n; g++)
		begin
			if (mode == AVG_PICK)
				acc = samples[g*grp + grp - 1];
			else
			begin
				acc = '0;
				for (int k = 0; k < grp; k++)
					for (int i = 0; i < LANES; i++)
						acc[i] = acc[i] + samples[g*grp + k][i]; // lane wrap
			end
			dec_q.push_back(acc);
		end
		if (!pk)
			exp_q = dec_q;
		else
		begin
			n_words = dec_q.size() * CHUNK_W / WORD_W; // whole words only
			for (int w = 0; w < n_words; w++)
			begin
				for (int b = 0; b < WORD_W; b++)
				begin
					s = w * WORD_W + b;
					bits[b] = dec_q[s / CHUNK_W][(s % CHUNK_W) / CONV_W][(s % CHUNK_W) % CONV_W];
				end
				exp_q.push_back(bits);
			end
		end
		while (exp_q.size() > len)
			void'(exp_q.pop_back());
	endfunction

	task automatic fill_samples(input int n);
		logic [31:0] r;
		for (int k = 0; k < n; k++)
			for (int i = 0; i < LANES; i++)
			begin
				r = $urandom;
				samples[k][i] = {4'h0, r[11:0]};
			end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge adc_clkinp);
			#2;
		end
	endtask

	task automatic pulse_state_reset();
		state_reset = 1'b1;
		idle_cycles(1);
		state_reset = 1'b0;
		check_flag(rcv_done, 1'b0, "rcv_done");
		check_flag(trig_ack, 1'b0, "trig_ack");
	endtask

	task automatic start_capture(input decim_t div, input avg_mode_t mode, input logic pk,
		input int len);
		logic [31:0] r;
		decim_div = div;
		avg_mode = mode;
		pack_en = pk;
		rec_length = len[ADDR_W:0];
		trig_in = 1'b1;
		idle_cycles(1); // trigger edge
		trig_in = 1'b0;
		r = $urandom; // scramble, options already latched
		rec_length = r[ADDR_W:0];
		decim_div = r[19:16];
		avg_mode = avg_mode_t'(r[20]);
		pack_en = r[21];
	endtask

	task automatic drive_samples(input int first, input int count);
		for (int k = 0; k < count; k++)
		begin
			adc_sample = samples[first + k];
			idle_cycles(1);
		end
	endtask

	task automatic wait_done(input int len);
		while (!rcv_done)
			idle_cycles(1);
		check_flag(trig_ack, 1'b0, "trig_ack");
		check_flag(ram_en, 1'b0, "ram_en");
		if (wr_idx != len)
			abort_run($sformatf("record ended with %0d writes, expected %0d", wr_idx, len));
		idle_cycles(10); // any late write is caught by the checker
		check_flag(rcv_done, 1'b1, "rcv_done");
	endtask

	task automatic run_capture(input int n, input decim_t div, input avg_mode_t mode,
		input logic pk, input int len);
		fill_samples(n);
		build_expected(n, div, mode, pk, len);
		wr_idx = 0;
		expect_writes = 1'b1;
		pulse_state_reset();
		start_capture(div, mode, pk, len);
		drive_samples(0, n);
		wait_done(len);
	endtask

	// compare every ram write with the next expected word
	always @(negedge adc_clkinp)
	begin
		if (rst_n && ram_wren)
		begin
			if (!expect_writes || wr_idx >= exp_q.size())
				report_mismatch($sformatf("unexpected write at address %0d", ram_addr));
			else
			begin
				check_word(ram_data, exp_q[wr_idx], wr_idx);
				check_addr(ram_addr, wr_idx[ADDR_W-1:0]);
				check_flag(trig_ack, 1'b1, "trig_ack");
				check_flag(ram_en, 1'b1, "ram_en");
				wr_idx++;
			end
		end
	end

	always @(posedge adc_clkinp)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
			abort_run($sformatf("timeout, run still going after %0d cycles", cycles));
	end

	initial
	begin
		adc_clkinp = 1'b0;
		rst_n = 1'b0;
		adc_sample = '0;
		trig_in = 1'b0;
		state_reset = 1'b0;
		rec_length = '0;
		decim_div = '0;
		avg_mode = AVG_PICK;
		pack_en = 1'b0;
		wr_idx = 0;
		expect_writes = 1'b0;
		cycles = 0;
		void'($urandom(63264));
		repeat (5) @(posedge adc_clkinp);
		#2;
		rst_n = 1'b1;

		repeat (3)
		begin
			check_flag(trig_ack, 1'b0, "trig_ack");
			check_flag(rcv_done, 1'b0, "rcv_done");
			check_flag(ram_en, 1'b0, "ram_en");
			check_flag(ram_wren, 1'b0, "ram_wren");
			check_addr(ram_addr, '0);
			idle_cycles(1);
		end

		run_capture(N_PLAIN, 4'd0, AVG_PICK, 1'b0, 20);
		run_capture(N_PICK, 4'd3, AVG_PICK, 1'b0, 10);
		run_capture(N_SUM, 4'd2, AVG_SUM, 1'b0, 10);
		run_capture(N_PACK0, 4'd0, AVG_PICK, 1'b1, 7); // ends inside a group
		run_capture(N_PACK1, 4'd1, AVG_SUM, 1'b1, 7);

		// abort in mid record
		fill_samples(N_ABORT);
		build_expected(N_ABORT, 4'd0, AVG_PICK, 1'b0, 20);
		wr_idx = 0;
		expect_writes = 1'b1;
		pulse_state_reset();
		start_capture(4'd0, AVG_PICK, 1'b0, 20);
		drive_samples(0, 8);
		pulse_state_reset();
		expect_writes = 1'b0;
		check_flag(ram_en, 1'b0, "ram_en");
		if (wr_idx == 0)
			abort_run("abort test saw no write before state_reset");
		drive_samples(8, N_ABORT - 8);
		check_flag(rcv_done, 1'b0, "rcv_done");
		check_flag(trig_ack, 1'b0, "trig_ack");

		// trigger while done has no effect
		run_capture(N_DONE, 4'd0, AVG_PICK, 1'b0, 5);
		expect_writes = 1'b0;
		start_capture(4'd0, AVG_PICK, 1'b0, 5);
		drive_samples(0, N_IGNORED);
		check_flag(trig_ack, 1'b0, "trig_ack");
		check_flag(rcv_done, 1'b1, "rcv_done");

		run_capture(N_REARM, 4'd0, AVG_PICK, 1'b0, 12); // fresh record from address 0

		$display("all tests passed");
		$finish;
	end

endmodule

//--- verilog.f
adc_capture_pkg.sv
capture_cfg_if.sv
capture_config.sv
capture_sequencer.sv
sample_decimator.sv
sample_packer.sv
adc_capture_top.sv
tb_adc_capture.sv
